// File: design/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

////////////////////////////////
// Datapath widths
////////////////////////////////
`define XLEN          32
`define REG_ADDR_LEN  5
`define PC_LEN        8

////////////////////////////////
// Buffer sizes and latencies
////////////////////////////////
`define ROB_SIZE      8
`define ROB_TAG_LEN   3       // log2 of ROB_SIZE.
`define FETCH_DEPTH   4
`define MUL_LATENCY   3

`endif

// File: design/isa_pkg.sv
`default_nettype none

`include "rob_params.svh"

package isa_pkg;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_beq = 2'd3             // Predicted not taken.
    } op_kind_t;

    typedef struct packed {
        logic [`PC_LEN-1:0]       pc;
        op_kind_t                 kind;
        logic [`REG_ADDR_LEN-1:0] dest;
        logic [`XLEN-1:0]         a;
        logic [`XLEN-1:0]         b;
        logic [`PC_LEN-1:0]       target;  // Branch target.
    } instr_t;

endpackage

`default_nettype wire

// File: design/rob_pkg.sv
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

    typedef struct packed {
        logic                     valid;
        logic                     ready;       // Result written back.
        logic                     mispredict;
        logic                     writes_reg;
        logic [`PC_LEN-1:0]       pc;
        logic [`REG_ADDR_LEN-1:0] dest;
        logic [`XLEN-1:0]         data;
        logic [`PC_LEN-1:0]       target;
    } rob_entry_t;

    typedef struct packed {
        rob_tag_t           tag;
        logic [`XLEN-1:0]   data;
        logic               mispredict;
        logic [`PC_LEN-1:0] target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: design/ring_fifo.sv
`default_nettype none

module ring_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == cnt_w'(depth));
    assign empty    = (count == '0);
    assign pop_data = mem[head];
    assign do_push  = push && !full;   // Push into a full buffer is ignored.
    assign do_pop   = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) tail <= bump(tail);
            if (do_pop) head <= bump(head);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[tail] <= push_data;
    end

endmodule

`default_nettype wire

// File: design/dispatch_unit.sv
`default_nettype none

`include "rob_params.svh"

module dispatch_unit (
    input  isa_pkg::instr_t           head_instr,
    input  logic                      head_valid,
    output logic                      pop,
    input  logic                      rob_full,
    input  rob_pkg::rob_tag_t         rob_tag,
    output logic                      rob_alloc,
    output logic [`PC_LEN-1:0]        alloc_pc,
    output logic [`REG_ADDR_LEN-1:0]  alloc_dest,
    output logic                      alloc_writes_reg,
    output logic [`PC_LEN-1:0]        alloc_target,
    output logic                      alu_issue,
    output logic                      mul_issue,
    output rob_pkg::rob_tag_t         issue_tag,
    output isa_pkg::instr_t           issue_instr
);

    import isa_pkg::*;

    logic go;
    logic to_mul;

    // Both units take one op per cycle, so only the ROB can stall.
    assign go     = head_valid && !rob_full;
    assign to_mul = (head_instr.kind == op_mul);

    assign pop       = go;
    assign rob_alloc = go;
    assign alu_issue = go && !to_mul;
    assign mul_issue = go && to_mul;

    assign alloc_pc         = head_instr.pc;
    assign alloc_dest       = head_instr.dest;
    assign alloc_writes_reg = (head_instr.kind != op_beq);  // Branches write nothing.
    assign alloc_target     = head_instr.target;

    assign issue_tag   = rob_tag;     // Tail tag of the ROB.
    assign issue_instr = head_instr;

endmodule

`default_nettype wire

// File: design/alu_unit.sv
`default_nettype none

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue,
    input  rob_pkg::rob_tag_t     issue_tag,
    input  isa_pkg::instr_t       issue_instr,
    output logic                  res_valid,
    output rob_pkg::exec_result_t res
);

    import isa_pkg::*;
    import rob_pkg::*;

    exec_result_t next_res;

    always_comb begin
        next_res.tag        = issue_tag;
        next_res.target     = issue_instr.target;
        next_res.mispredict = 1'b0;
        case (issue_instr.kind)
            op_add:  next_res.data = issue_instr.a + issue_instr.b;
            op_sub:  next_res.data = issue_instr.a - issue_instr.b;
            op_beq: begin
                next_res.data       = '0;
                next_res.mispredict = (issue_instr.a == issue_instr.b);  // Taken.
            end
            default: next_res.data = '0;  // Multiplies go elsewhere.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) res_valid <= 1'b0;
        else              res_valid <= issue;
    end

    always_ff @(posedge clk) begin
        res <= next_res;
    end

endmodule

`default_nettype wire

// File: design/mul_unit.sv
`default_nettype none

`include "rob_params.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue,
    input  rob_pkg::rob_tag_t     issue_tag,
    input  isa_pkg::instr_t       issue_instr,
    output logic                  res_valid,
    output rob_pkg::exec_result_t res
);

    import rob_pkg::*;

    logic [`MUL_LATENCY-1:0] stage_valid;
    rob_tag_t                stage_tag  [`MUL_LATENCY];
    logic [`XLEN-1:0]        stage_prod [`MUL_LATENCY];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue;
            for (int i = 1; i < `MUL_LATENCY; i++) stage_valid[i] <= stage_valid[i-1];
        end
    end

    always_ff @(posedge clk) begin
        stage_tag[0]  <= issue_tag;
        stage_prod[0] <= issue_instr.a * issue_instr.b;  // Low XLEN bits only.
        for (int i = 1; i < `MUL_LATENCY; i++) begin
            stage_tag[i]  <= stage_tag[i-1];
            stage_prod[i] <= stage_prod[i-1];
        end
    end

    assign res_valid      = stage_valid[`MUL_LATENCY-1];
    assign res.tag        = stage_tag[`MUL_LATENCY-1];
    assign res.data       = stage_prod[`MUL_LATENCY-1];
    assign res.mispredict = 1'b0;
    assign res.target     = '0;

endmodule

`default_nettype wire

// File: design/cdb_arbiter.sv
`default_nettype none

`include "rob_params.svh"

module cdb_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  alu_valid,
    input  rob_pkg::exec_result_t alu_res,
    input  logic                  mul_valid,
    input  rob_pkg::exec_result_t mul_res,
    output logic                  cdb_valid,
    output rob_pkg::exec_result_t cdb_result
);

    import rob_pkg::*;

    exec_result_t fifo_head;
    logic         fifo_empty;
    logic         fifo_pop;

    // Never more than ROB_SIZE ops in flight, so this buffer never fills.
    ring_fifo #(
        .payload_t (exec_result_t),
        .depth     (`ROB_SIZE)
    ) alu_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (alu_valid),
        .push_data (alu_res),
        .full      (),
        .pop       (fifo_pop),
        .pop_data  (fifo_head),
        .empty     (fifo_empty)
    );

    // Multiplier wins since its pipeline cannot stall.
    assign fifo_pop   = !mul_valid && !fifo_empty;
    assign cdb_valid  = mul_valid || !fifo_empty;
    assign cdb_result = mul_valid ? mul_res : fifo_head;

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
`default_nettype none

`include "rob_params.svh"

module reorder_buffer (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     dispatch,
    input  logic [`PC_LEN-1:0]       alloc_pc,
    input  logic [`REG_ADDR_LEN-1:0] alloc_dest,
    input  logic                     alloc_writes_reg,
    input  logic [`PC_LEN-1:0]       alloc_target,
    output rob_pkg::rob_tag_t        tail_tag,
    output logic                     rob_full,

    input  logic                     cdb_valid,
    input  rob_pkg::exec_result_t    cdb_result,

    output logic                     retire_valid,
    output logic [`PC_LEN-1:0]       retire_pc,
    output logic                     retire_we,
    output logic [`REG_ADDR_LEN-1:0] retire_reg,
    output logic [`XLEN-1:0]         retire_data,

    output logic                     flush,
    output logic [`PC_LEN-1:0]       redirect_pc
);

    import rob_pkg::*;

    localparam logic [`ROB_TAG_LEN:0] full_count = `ROB_SIZE;

    rob_entry_t               entries [`ROB_SIZE];
    rob_entry_t               head_entry;
    rob_tag_t                 head;
    rob_tag_t                 tail;
    logic [`ROB_TAG_LEN:0]    count;

    ////////////////////////////////
    // Retirement of the head entry
    ////////////////////////////////
    assign head_entry   = entries[head];
    assign retire_valid = head_entry.valid && head_entry.ready;
    assign retire_pc    = head_entry.pc;
    assign retire_we    = retire_valid && head_entry.writes_reg;
    assign retire_reg   = head_entry.dest;
    assign retire_data  = head_entry.data;
    assign flush        = retire_valid && head_entry.mispredict;  // Taken branch.
    assign redirect_pc  = head_entry.target;

    assign tail_tag = tail;
    assign rob_full = (count == full_count);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `ROB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (dispatch) begin
                entries[tail] <= '{valid: 1'b1, ready: 1'b0, mispredict: 1'b0,
                                   writes_reg: alloc_writes_reg, pc: alloc_pc,
                                   dest: alloc_dest, data: '0, target: alloc_target};
                tail <= tail + 1'b1;
            end
            if (cdb_valid) begin
                entries[cdb_result.tag].ready      <= 1'b1;
                entries[cdb_result.tag].data       <= cdb_result.data;
                entries[cdb_result.tag].mispredict <= cdb_result.mispredict;
                entries[cdb_result.tag].target     <= cdb_result.target;
            end
            if (retire_valid) begin
                entries[head].valid <= 1'b0;
                head <= head + 1'b1;
            end
            case ({dispatch, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rob_core.sv
`default_nettype none

`include "rob_params.svh"

module rob_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  isa_pkg::instr_t          in_instr,
    output logic                     in_ready,
    output logic                     retire_valid,
    output logic [`PC_LEN-1:0]       retire_pc,
    output logic                     retire_we,
    output logic [`REG_ADDR_LEN-1:0] retire_reg,
    output logic [`XLEN-1:0]         retire_data,
    output logic                     redirect_valid,
    output logic [`PC_LEN-1:0]       redirect_pc
);

    import isa_pkg::*;
    import rob_pkg::*;

    instr_t                   fetch_head, issue_instr;
    logic                     fetch_full, fetch_empty, fetch_pop;
    logic                     rob_full, rob_alloc, flush;
    rob_tag_t                 tail_tag, issue_tag;
    logic [`PC_LEN-1:0]       alloc_pc, alloc_target;
    logic [`REG_ADDR_LEN-1:0] alloc_dest;
    logic                     alloc_writes_reg, alu_issue, mul_issue;
    logic                     alu_valid, mul_valid, cdb_valid;
    exec_result_t             alu_res, mul_res, cdb_result;

    assign in_ready       = !fetch_full;
    assign redirect_valid = flush;

    ring_fifo #(.payload_t(instr_t), .depth(`FETCH_DEPTH)) fetch_buffer_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .push(in_valid), .push_data(in_instr), .full(fetch_full),
        .pop(fetch_pop), .pop_data(fetch_head), .empty(fetch_empty)
    );

    dispatch_unit dispatch_unit_inst (
        .head_instr(fetch_head), .head_valid(!fetch_empty), .pop(fetch_pop),
        .rob_full(rob_full), .rob_tag(tail_tag), .rob_alloc(rob_alloc),
        .alloc_pc(alloc_pc), .alloc_dest(alloc_dest),
        .alloc_writes_reg(alloc_writes_reg), .alloc_target(alloc_target),
        .alu_issue(alu_issue), .mul_issue(mul_issue),
        .issue_tag(issue_tag), .issue_instr(issue_instr)
    );

    alu_unit alu_unit_inst (
        .clk(clk), .rst(rst), .flush(flush), .issue(alu_issue),
        .issue_tag(issue_tag), .issue_instr(issue_instr),
        .res_valid(alu_valid), .res(alu_res)
    );

    mul_unit mul_unit_inst (
        .clk(clk), .rst(rst), .flush(flush), .issue(mul_issue),
        .issue_tag(issue_tag), .issue_instr(issue_instr),
        .res_valid(mul_valid), .res(mul_res)
    );

    cdb_arbiter cdb_arbiter_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .alu_valid(alu_valid), .alu_res(alu_res),
        .mul_valid(mul_valid), .mul_res(mul_res),
        .cdb_valid(cdb_valid), .cdb_result(cdb_result)
    );

    reorder_buffer reorder_buffer_inst (
        .clk(clk), .rst(rst), .dispatch(rob_alloc),
        .alloc_pc(alloc_pc), .alloc_dest(alloc_dest),
        .alloc_writes_reg(alloc_writes_reg), .alloc_target(alloc_target),
        .tail_tag(tail_tag), .rob_full(rob_full),
        .cdb_valid(cdb_valid), .cdb_result(cdb_result),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_reg(retire_reg), .retire_data(retire_data),
        .flush(flush), .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

// File: dv/rob_core_tb.sv
`default_nettype none

`include "rob_params.svh"

module rob_core_tb;

    import isa_pkg::*;

    localparam int prog_len       = 40;
    localparam int timeout_cycles = prog_len * (`MUL_LATENCY + `ROB_SIZE + 4);

    typedef struct packed {
        logic [`PC_LEN-1:0]       pc;
        logic                     we;
        logic [`REG_ADDR_LEN-1:0] dest;
        logic [`XLEN-1:0]         data;
        logic                     redirect;   // Taken branch.
        logic [`PC_LEN-1:0]       target;
    } retire_rec_t;

    logic                     clk      = 1'b0;
    logic                     rst      = 1'b1;
    logic                     in_valid = 1'b0;
    instr_t                   in_instr = '0;
    logic                     in_ready;
    logic                     retire_valid;
    logic [`PC_LEN-1:0]       retire_pc;
    logic                     retire_we;
    logic [`REG_ADDR_LEN-1:0] retire_reg;
    logic [`XLEN-1:0]         retire_data;
    logic                     redirect_valid;
    logic [`PC_LEN-1:0]       redirect_pc;

    instr_t      program_mem [prog_len];
    retire_rec_t expected [$];
    logic [31:0] lfsr_state;
    int          fetch_pc    = 0;
    int          exp_idx     = 0;
    int          cycle_count = 0;

    always #5 clk = ~clk;

    rob_core rob_core_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_reg(retire_reg), .retire_data(retire_data),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    //////////////////////////////
    // Stimulus source
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic void make_program();
        instr_t      ins;
        logic [31:0] bits;
        int          t;
        for (int pc = 0; pc < prog_len; pc++) begin
            ins        = '0;
            ins.pc     = 8'(pc);
            bits       = take_bits(2);
            ins.kind   = op_kind_t'(bits[1:0]);
            bits       = take_bits(5);
            ins.dest   = bits[4:0];
            ins.a      = 32'(take_bits(8));
            ins.b      = 32'(take_bits(8));
            if (ins.kind == op_beq) begin
                bits = take_bits(2);
                if (bits[1:0] == 2'd0) ins.b = ins.a;  // Forced taken.
                bits = take_bits(2);
                t    = pc + 2 + int'(bits[1:0]);
                if (t > prog_len) t = prog_len;
                ins.target = 8'(t);
            end
            if (pc >= 24 && pc < 32) ins.kind = op_mul;  // Keeps the multiplier busy.
            program_mem[pc] = ins;
        end
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic void build_expected();
        instr_t      ins;
        retire_rec_t rec;
        int          pc;
        pc = 0;
        expected.delete();
        while (pc < prog_len) begin
            ins          = program_mem[pc];
            rec.pc       = ins.pc;
            rec.dest     = ins.dest;
            rec.target   = ins.target;
            rec.we       = (ins.kind != op_beq);
            rec.redirect = 1'b0;
            case (ins.kind)
                op_add:  rec.data = ins.a + ins.b;
                op_sub:  rec.data = ins.a - ins.b;
                op_mul:  rec.data = ins.a * ins.b;
                default: begin
                    rec.data     = '0;
                    rec.redirect = (ins.a == ins.b);
                end
            endcase
            expected.push_back(rec);
            pc = rec.redirect ? int'(ins.target) : pc + 1;
        end
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("** Error %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
            abort_run("retired state differs from the reference");
        end
    endtask

    // Front end presents the instruction at fetch_pc and follows redirects.
    always @(posedge clk) begin : front_end
        int npc;
        npc = fetch_pc;
        if (rst) begin
            fetch_pc <= 0;
            in_valid <= 1'b0;
        end else begin
            if (redirect_valid) npc = int'(redirect_pc);
            else if (in_valid && in_ready) npc = fetch_pc + 1;
            fetch_pc <= npc;
            in_valid <= (npc < prog_len);
            if (npc < prog_len) in_instr <= program_mem[npc];
        end
    end

    always @(posedge clk) begin : compare_retire
        retire_rec_t rec;
        if (!rst && retire_valid) begin
            if (exp_idx >= expected.size()) begin
                abort_run("an instruction retired after the end of the program");
            end else begin
                rec = expected[exp_idx];
                check_value($sformatf("retire_pc[%0d]", exp_idx), 32'(rec.pc), 32'(retire_pc));
                check_value($sformatf("retire_we[%0d]", exp_idx), 32'(rec.we), 32'(retire_we));
                if (rec.we) begin
                    check_value($sformatf("retire_reg[%0d]", exp_idx), 32'(rec.dest),
                                32'(retire_reg));
                end
                check_value($sformatf("retire_data[%0d]", exp_idx), rec.data, retire_data);
                check_value($sformatf("redirect_valid[%0d]", exp_idx), 32'(rec.redirect),
                            32'(redirect_valid));
                if (rec.redirect) begin
                    check_value($sformatf("redirect_pc[%0d]", exp_idx), 32'(rec.target),
                                32'(redirect_pc));
                end
                exp_idx <= exp_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            abort_run($sformatf("Timeout: retirement stalled, %0d of %0d records after %0d cycles",
                                exp_idx, expected.size(), cycle_count));
        end
    end

    initial begin
        lfsr_state = 32'h578f;
        make_program();
        build_expected();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("in_ready_after_reset", 32'd1, 32'(in_ready));
        check_value("retire_valid_after_reset", 32'd0, 32'(retire_valid));
        check_value("redirect_valid_after_reset", 32'd0, 32'(redirect_valid));
        while (exp_idx < expected.size()) @(posedge clk);
        repeat (`MUL_LATENCY + 4) @(posedge clk);  // Catch late extra retires.
        if (exp_idx == expected.size()) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("retirement count does not match the reference");
        end
    end

endmodule

`default_nettype wire

// File: rob_core.f
+incdir+design
design/isa_pkg.sv
design/rob_pkg.sv
design/ring_fifo.sv
design/dispatch_unit.sv
design/alu_unit.sv
design/mul_unit.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/rob_core.sv
dv/rob_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_core_tb
FILELIST  ?= rob_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
